//--- mxd_distributor.sv
// Multi-transfer distributor top with arbiter, priority pointer, core and counter
`timescale 1ns/100ps
`default_nettype none

module mxd_distributor #(
  parameter int num_symbols = mxd_geom_pkg::NUM_SYMBOLS,
  parameter int symbol_width = mxd_geom_pkg::SYMBOL_WIDTH,
  parameter int num_flows = mxd_geom_pkg::NUM_FLOWS,
  localparam int count_w = mxd_geom_pkg::count_width(num_symbols),
  localparam int ptr_w = $clog2(num_flows)
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [count_w-1:0]                      push_sendable,
  output logic [count_w-1:0]                      push_receivable,
  input  logic [num_symbols-1:0][symbol_width-1:0] push_data,
  output logic [num_flows-1:0]                    pop_valid,
  input  logic [num_flows-1:0]                    pop_ready,
  output logic [num_flows-1:0][symbol_width-1:0]  pop_data,
  input  logic                                    stat_clear,
  output mxd_stats_pkg::xfer_count_t               xfer_count
);

  logic [num_flows-1:0]                 request;
  logic [count_w-1:0]                   grant_allowed;
  logic [num_flows-1:0]                 grant;
  logic [num_symbols-1:0][num_flows-1:0] grant_ordered;
  logic [count_w-1:0]                   grant_count;
  logic [ptr_w-1:0]                     priority_ptr;
  logic [ptr_w-1:0]                     last_grant_idx;
  logic                                 any_grant;

  mxd_priority_state #(
    .num_flows(num_flows)
  ) u_priority_state (
    .clk            (clk),
    .rst_n          (rst_n),
    .any_grant      (any_grant),
    .last_grant_idx (last_grant_idx),
    .priority_ptr   (priority_ptr)
  );

  mxd_multi_grant_arbiter #(
    .num_symbols(num_symbols),
    .num_flows  (num_flows)
  ) u_arbiter (
    .priority_ptr   (priority_ptr),
    .request        (request),
    .grant_allowed  (grant_allowed),
    .grant          (grant),
    .grant_ordered  (grant_ordered),
    .grant_count    (grant_count),
    .last_grant_idx (last_grant_idx),
    .any_grant      (any_grant)
  );

  mxd_distributor_core #(
    .num_symbols (num_symbols),
    .symbol_width(symbol_width),
    .num_flows   (num_flows)
  ) u_core (
    .clk             (clk),
    .rst_n           (rst_n),
    .push_sendable   (push_sendable),
    .push_receivable (push_receivable),
    .push_data       (push_data),
    .pop_valid       (pop_valid),
    .pop_ready       (pop_ready),
    .pop_data        (pop_data),
    .request         (request),
    .grant_allowed   (grant_allowed),
    .grant           (grant),
    .grant_ordered   (grant_ordered),
    .grant_count     (grant_count)
  );

  // Symbols taken this cycle are the symbols delivered
  mxd_xfer_counter #(
    .num_symbols(num_symbols)
  ) u_xfer_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .stat_clear (stat_clear),
    .incr       (push_receivable),
    .xfer_count (xfer_count)
  );

endmodule : mxd_distributor

`default_nettype wire

//--- mxd_distributor_core.sv
// Distributor core with handshake mapping, per-flow symbol select and protocol checks
`timescale 1ns/100ps
`default_nettype none

module mxd_distributor_core #(
  parameter int num_symbols = mxd_geom_pkg::NUM_SYMBOLS,
  parameter int symbol_width = mxd_geom_pkg::SYMBOL_WIDTH,
  parameter int num_flows = mxd_geom_pkg::NUM_FLOWS,
  localparam int count_w = mxd_geom_pkg::count_width(num_symbols)
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [count_w-1:0]                      push_sendable,
  output logic [count_w-1:0]                      push_receivable,
  input  logic [num_symbols-1:0][symbol_width-1:0] push_data,
  output logic [num_flows-1:0]                    pop_valid,
  input  logic [num_flows-1:0]                    pop_ready,
  output logic [num_flows-1:0][symbol_width-1:0]  pop_data,
  output logic [num_flows-1:0]                    request,
  output logic [count_w-1:0]                      grant_allowed,
  input  logic [num_flows-1:0]                    grant,
  input  logic [num_symbols-1:0][num_flows-1:0]   grant_ordered,
  input  logic [count_w-1:0]                      grant_count
);

  // Per flow, which symbol slot feeds it
  logic [num_flows-1:0][num_symbols-1:0]   flow_select;
  // Symbols that stay behind after this edge, moved down to slot 0
  logic [count_w-1:0]                      left_over;
  logic [num_symbols-1:0][symbol_width-1:0] left_over_data;

  if (num_symbols < 2) begin : gen_bad_num_symbols
    $error("num_symbols must be at least 2");
  end
  if (symbol_width < 1) begin : gen_bad_symbol_width
    $error("symbol_width must be at least 1");
  end
  if (num_flows < num_symbols) begin : gen_bad_num_flows
    $error("num_flows must be at least num_symbols");
  end

  // Ready flows request, sendable count bounds the grants
  assign request         = pop_ready;
  assign grant_allowed   = push_sendable;
  assign pop_valid       = grant;
  assign push_receivable = grant_count;

  for (genvar f = 0; f < num_flows; f++) begin : gen_flow_select
    for (genvar j = 0; j < num_symbols; j++) begin : gen_symbol
      assign flow_select[f][j] = grant_ordered[j][f];
    end
  end

  // One-hot AND-OR mux per flow
  always_comb begin : pop_mux
    for (int f = 0; f < num_flows; f++) begin
      pop_data[f] = '0;
      for (int j = 0; j < num_symbols; j++) begin
        pop_data[f] |= push_data[j] & {symbol_width{flow_select[f][j]}};
      end
    end
  end

  assign left_over = push_sendable - push_receivable;

  always_comb begin : shift_left_over
    for (int j = 0; j < num_symbols; j++) begin
      left_over_data[j] = '0;
      if (j + int'(push_receivable) < num_symbols) begin
        left_over_data[j] = push_data[j + int'(push_receivable)];
      end
    end
  end

  grant_count_le_allowed_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    grant_count <= grant_allowed
  ) else $error("grant_count exceeds grant_allowed");

  for (genvar f = 0; f < num_flows; f++) begin : gen_select_check
    select_onehot0_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      $onehot0(flow_select[f])
    ) else $error("flow %0d selects more than one symbol", f);
  end

  pop_valid_le_sendable_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(pop_valid) <= push_sendable
  ) else $error("more pops than symbols offered");

  receivable_le_ready_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    push_receivable <= $countones(pop_ready)
  ) else $error("push_receivable exceeds ready flows");

  // Sender must keep offering what was not taken
  sendable_held_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    (left_over != '0) |=> (push_sendable >= $past(left_over))
  ) else $error("unconsumed symbols withdrawn");

  for (genvar j = 0; j < num_symbols; j++) begin : gen_stable_check
    left_over_stable_a : assert property (
      @(posedge clk) disable iff (!rst_n)
      (left_over > j) |=> (push_data[j] == $past(left_over_data[j]))
    ) else $error("re-offered symbol %0d changed", j);
  end

endmodule : mxd_distributor_core

`default_nettype wire

//--- mxd_geom_pkg.sv
// Datapath geometry defaults and the count width rule
`default_nettype none

package mxd_geom_pkg;

  // Symbols offered per push cycle, at least 2
  localparam int NUM_SYMBOLS = 4;

  // Bits per symbol, at least 1
  localparam int SYMBOL_WIDTH = 8;

  // Output flows, never fewer than NUM_SYMBOLS
  localparam int NUM_FLOWS = 6;

  // Bits needed to hold any count from 0 to n
  function automatic int count_width(input int n);
    return $clog2(n + 1);
  endfunction

endpackage : mxd_geom_pkg

`default_nettype wire

//--- mxd_multi_grant_arbiter.sv
// Multi-grant round-robin arbiter with symbol-to-flow ordering and grant count
`timescale 1ns/100ps
`default_nettype none

module mxd_multi_grant_arbiter #(
  parameter int num_symbols = mxd_geom_pkg::NUM_SYMBOLS,
  parameter int num_flows = mxd_geom_pkg::NUM_FLOWS,
  localparam int count_w = mxd_geom_pkg::count_width(num_symbols),
  localparam int ptr_w = $clog2(num_flows)
) (
  input  logic [ptr_w-1:0]                     priority_ptr,
  input  logic [num_flows-1:0]                 request,
  input  logic [count_w-1:0]                   grant_allowed,
  output logic [num_flows-1:0]                 grant,
  output logic [num_symbols-1:0][num_flows-1:0] grant_ordered,
  output logic [count_w-1:0]                   grant_count,
  output logic [ptr_w-1:0]                     last_grant_idx,
  output logic                                 any_grant
);

  // Requests in scan order, bit k belongs to flow (ptr + k) mod num_flows
  logic [num_flows-1:0] request_rot;
  // Upper bound on grants this cycle
  logic [count_w-1:0]   grant_limit;
  // All flows named by any symbol slot
  logic [num_flows-1:0] ordered_union;

  // Never grant more symbols than the push side can carry
  assign grant_limit = (grant_allowed > count_w'(num_symbols)) ?
                       count_w'(num_symbols) : grant_allowed;

  // Rotate requests so the scan always starts at bit 0
  always_comb begin : rotate_requests
    int flow;
    for (int k = 0; k < num_flows; k++) begin
      flow = int'(priority_ptr) + k;
      if (flow >= num_flows) begin
        flow = flow - num_flows;
      end
      request_rot[k] = request[flow];
    end
  end

  // Walk the rotated requests, handing symbol slots out in order
  always_comb begin : scan_grants
    int flow;
    logic [count_w-1:0] granted;
    grant          = '0;
    grant_ordered  = '0;
    last_grant_idx = '0;
    granted        = '0;
    for (int k = 0; k < num_flows; k++) begin
      flow = int'(priority_ptr) + k;
      if (flow >= num_flows) begin
        flow = flow - num_flows;
      end
      if (request_rot[k] && (granted < grant_limit)) begin
        grant[flow]                  = 1'b1;
        grant_ordered[granted][flow] = 1'b1;
        // Latest hit in scan order is the last flow served
        last_grant_idx               = ptr_w'(flow);
        granted                      = granted + 1'b1;
      end
    end
    grant_count = granted;
  end

  assign any_grant = (grant_count != '0);

  always_comb begin : collect_ordered
    ordered_union = '0;
    for (int j = 0; j < num_symbols; j++) begin
      ordered_union |= grant_ordered[j];
    end
  end

  // Settled-value checks, skipped while inputs are still unknown
  always_comb begin : grant_checks
    if (!$isunknown(request) && !$isunknown(grant_allowed)) begin
      grant_within_request_a : assert final ((grant & ~request) == '0)
        else $error("grant %h outside request %h", grant, request);
      ordered_matches_grant_a : assert final (ordered_union == grant)
        else $error("grant_ordered union %h differs from grant %h",
                    ordered_union, grant);
    end
  end

endmodule : mxd_multi_grant_arbiter

`default_nettype wire

//--- mxd_priority_state.sv
// Round-robin priority pointer register with its advance rule and range checks
`timescale 1ns/100ps
`default_nettype none

module mxd_priority_state #(
  parameter int num_flows = mxd_geom_pkg::NUM_FLOWS,
  localparam int ptr_w = $clog2(num_flows)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             any_grant,
  input  logic [ptr_w-1:0] last_grant_idx,
  output logic [ptr_w-1:0] priority_ptr
);

  logic [ptr_w-1:0] next_ptr;

  // Start next search just past the last flow served, wrapping at the top
  always_comb begin
    if (last_grant_idx == ptr_w'(num_flows - 1)) begin
      next_ptr = '0;
    end else begin
      next_ptr = last_grant_idx + 1'b1;
    end
  end

  // Pointer only moves in cycles where some flow was served
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priority_ptr <= '0;
    end else if (any_grant) begin
      priority_ptr <= next_ptr;
    end
  end

  // Pointer must always name an existing flow
  priority_ptr_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    priority_ptr < num_flows
  ) else $error("priority_ptr %0d out of range", priority_ptr);

  // Arbiter may only report a served flow that exists
  last_grant_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    any_grant |-> (last_grant_idx < num_flows)
  ) else $error("last_grant_idx %0d out of range", last_grant_idx);

endmodule : mxd_priority_state

`default_nettype wire

//--- mxd_stats_pkg.sv
// Statistics counter width and the counter value type
`default_nettype none

package mxd_stats_pkg;

  // Width of the delivered symbol total
  localparam int XFER_COUNT_WIDTH = 16;

  // Running total of delivered symbols, saturates at all ones
  typedef logic [XFER_COUNT_WIDTH-1:0] xfer_count_t;

endpackage : mxd_stats_pkg

`default_nettype wire

//--- mxd_xfer_counter.sv
// Saturating delivered-symbol counter with synchronous clear
`timescale 1ns/100ps
`default_nettype none

module mxd_xfer_counter #(
  parameter int num_symbols = mxd_geom_pkg::NUM_SYMBOLS,
  localparam int count_w = mxd_geom_pkg::count_width(num_symbols),
  localparam int sum_w = mxd_stats_pkg::XFER_COUNT_WIDTH + 1
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stat_clear,
  input  logic [count_w-1:0]        incr,
  output mxd_stats_pkg::xfer_count_t xfer_count
);

  // One extra bit catches the wrap past all ones
  logic [sum_w-1:0] sum;

  assign sum = {1'b0, xfer_count} + sum_w'(incr);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      xfer_count <= '0;
    end else if (stat_clear) begin
      xfer_count <= '0;
    end else if (sum[sum_w-1]) begin
      xfer_count <= '1;
    end else begin
      xfer_count <= sum[sum_w-2:0];
    end
  end

  // Total only drops through a clear
  count_monotonic_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    !stat_clear |=> (xfer_count >= $past(xfer_count))
  ) else $error("xfer_count decreased without stat_clear");

endmodule : mxd_xfer_counter

`default_nettype wire

//--- sim.f
mxd_geom_pkg.sv
mxd_stats_pkg.sv
mxd_priority_state.sv
mxd_multi_grant_arbiter.sv
mxd_distributor_core.sv
mxd_xfer_counter.sv
mxd_distributor.sv
tb_mxd_distributor.sv

//--- tb_mxd_distributor.sv
// Directed testbench for the distributor with reference model, LFSR and compare tasks
`timescale 1ns/100ps
`default_nettype none

module tb_mxd_distributor;

  localparam int num_symbols = mxd_geom_pkg::NUM_SYMBOLS;
  localparam int symbol_width = mxd_geom_pkg::SYMBOL_WIDTH;
  localparam int num_flows = mxd_geom_pkg::NUM_FLOWS;
  localparam int count_w = mxd_geom_pkg::count_width(num_symbols);
  localparam int reset_cycles = 8;
  localparam int drain_limit = 32;
  localparam logic [15:0] lfsr_seed = 16'd59637;

  logic                                    clk;
  logic                                    rst_n;
  logic [count_w-1:0]                      push_sendable;
  logic [count_w-1:0]                      push_receivable;
  logic [num_symbols-1:0][symbol_width-1:0] push_data;
  logic [num_flows-1:0]                    pop_valid;
  logic [num_flows-1:0]                    pop_ready;
  logic [num_flows-1:0][symbol_width-1:0]  pop_data;
  logic                                    stat_clear;
  mxd_stats_pkg::xfer_count_t               xfer_count;

  // Reference model state that advances once per clock edge
  int                         model_ptr;
  mxd_stats_pkg::xfer_count_t model_total;
  logic [num_flows-1:0]       exp_valid;
  int                         exp_sym [num_flows];
  int                         exp_recv;
  int                         exp_last;

  // Symbols not yet taken stay at the front of the sender queue
  logic [symbol_width-1:0]                 pending [$];
  logic [num_symbols-1:0][symbol_width-1:0] offered;
  int                                      held;
  logic [count_w-1:0]                      sampled_recv;
  logic [15:0]                             lfsr_state;

  int count_errors;
  int flag_errors;
  int symbol_errors;
  int stat_errors;
  int timeout_errors;

  mxd_distributor dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .push_sendable   (push_sendable),
    .push_receivable (push_receivable),
    .push_data       (push_data),
    .pop_valid       (pop_valid),
    .pop_ready       (pop_ready),
    .pop_data        (pop_data),
    .stat_clear      (stat_clear),
    .xfer_count      (xfer_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_count(input string name, input logic [count_w-1:0] exp,
                             input logic [count_w-1:0] act);
    if (act !== exp) begin
      count_errors++;
      $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input logic [num_flows-1:0] exp,
                             input logic [num_flows-1:0] act);
    if (act !== exp) begin
      flag_errors++;
      $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_symbol(input string name, input logic [symbol_width-1:0] exp,
                              input logic [symbol_width-1:0] act);
    if (act !== exp) begin
      symbol_errors++;
      $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  task automatic check_stat(input string name, input mxd_stats_pkg::xfer_count_t exp,
                            input mxd_stats_pkg::xfer_count_t act);
    if (act !== exp) begin
      stat_errors++;
      $display("Error %s: expected 0x%h, got 0x%h", name, exp, act);
    end
  endtask

  // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  task automatic draw_bits(input int n, output int unsigned value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | lfsr_state[0];
    end
  endtask

  // Scan from the pointer and give symbol j to the j-th ready flow
  task automatic predict(input logic [num_flows-1:0] ready, input int sendable);
    int flow;
    exp_valid = '0;
    exp_recv = 0;
    exp_last = 0;
    for (int k = 0; k < num_flows; k++) begin
      flow = (model_ptr + k) % num_flows;
      exp_sym[flow] = 0;
      if (ready[flow] && (exp_recv < sendable)) begin
        exp_valid[flow] = 1'b1;
        exp_sym[flow] = exp_recv;
        exp_last = flow;
        exp_recv++;
      end
    end
  endtask

  // One push cycle in which the sender never offers fewer symbols than it still holds
  task automatic offer_cycle(input logic [num_flows-1:0] ready, input int want,
                             input logic clear);
    int sendable;
    int unsigned bits;
    sendable = (want > num_symbols) ? num_symbols : want;
    if (sendable < held) begin
      sendable = held;
    end
    while (pending.size() < sendable) begin
      draw_bits(symbol_width, bits);
      pending.push_back(symbol_width'(bits));
    end
    offered = '0;
    for (int j = 0; j < sendable; j++) begin
      offered[j] = pending[j];
    end
    @(posedge clk);
    #2;
    pop_ready = ready;
    push_sendable = count_w'(sendable);
    push_data = offered;
    stat_clear = clear;
    #10;
    predict(ready, sendable);
    sampled_recv = push_receivable;
    check_flags("pop_valid", exp_valid, pop_valid);
    check_count("push_receivable", count_w'(exp_recv), push_receivable);
    for (int f = 0; f < num_flows; f++) begin
      if (exp_valid[f]) begin
        check_symbol($sformatf("pop_data[%0d]", f), offered[exp_sym[f]], pop_data[f]);
      end
    end
    check_stat("xfer_count", model_total, xfer_count);
    // What the coming edge does
    for (int j = 0; j < exp_recv; j++) begin
      void'(pending.pop_front());
    end
    held = sendable - exp_recv;
    if (clear) begin
      model_total = '0;
    end else if (model_total > ('1 - mxd_stats_pkg::xfer_count_t'(exp_recv))) begin
      model_total = '1;
    end else begin
      model_total = model_total + exp_recv;
    end
    if (exp_recv > 0) begin
      model_ptr = (exp_last + 1) % num_flows;
    end
  endtask

  // Keep re-offering until every held symbol is taken
  task automatic drain_pending(input bit random_ready);
    int unsigned bits;
    logic [num_flows-1:0] ready;
    int guard;
    guard = 0;
    while ((held != 0) && (guard < drain_limit)) begin
      ready = '1;
      if (random_ready) begin
        draw_bits(num_flows, bits);
        ready = num_flows'(bits);
      end
      offer_cycle(ready, 0, 1'b0);
      guard++;
    end
    if (held != 0) begin
      timeout_errors++;
      $display("Timeout: %0d symbols still not taken after %0d cycles", held, drain_limit);
    end
  endtask

  task automatic reset_state_test();
    offer_cycle('1, 0, 1'b0);
    check_flags("pop_valid", '0, pop_valid);
    check_count("push_receivable", '0, push_receivable);
    check_stat("xfer_count", '0, xfer_count);
  endtask

  task automatic full_rotation_test();
    int ptr_track;
    int flow;
    logic [num_flows-1:0] mask;
    ptr_track = model_ptr;
    for (int c = 0; c < 6; c++) begin
      offer_cycle('1, num_symbols, 1'b0);
      mask = '0;
      for (int j = 0; j < num_symbols; j++) begin
        flow = (ptr_track + j) % num_flows;
        mask[flow] = 1'b1;
        check_symbol($sformatf("pop_data[%0d]", flow), offered[j], pop_data[flow]);
      end
      check_flags("pop_valid", mask, pop_valid);
      ptr_track = (ptr_track + num_symbols) % num_flows;
    end
  endtask

  task automatic partial_ready_test();
    int unsigned ready_bits;
    int unsigned want_bits;
    for (int c = 0; c < 24; c++) begin
      draw_bits(num_flows, ready_bits);
      draw_bits(3, want_bits);
      offer_cycle(num_flows'(ready_bits), int'(want_bits % (num_symbols + 1)), 1'b0);
    end
    drain_pending(1'b1);
  endtask

  task automatic shortage_reoffer_test();
    logic [num_flows-1:0] ready;
    logic [symbol_width-1:0] carried;
    int ptr_now;
    drain_pending(1'b0);
    ready = '0;
    ready[0] = 1'b1;
    ready[num_flows-1] = 1'b1;
    offer_cycle(ready, num_symbols, 1'b0);
    check_count("push_receivable", count_w'($countones(ready)), sampled_recv);
    carried = pending[0];
    ptr_now = model_ptr;
    // First held symbol lands at the new pointer when every flow is ready
    offer_cycle('1, 0, 1'b0);
    check_symbol($sformatf("pop_data[%0d]", ptr_now), carried, pop_data[ptr_now]);
    for (int r = 0; r < 3; r++) begin
      ready = '0;
      ready[(model_ptr + r + 1) % num_flows] = 1'b1;
      offer_cycle(ready, num_symbols, 1'b0);
      check_count("push_receivable", count_w'(1), sampled_recv);
      drain_pending(1'b1);
    end
  endtask

  task automatic statistics_test();
    mxd_stats_pkg::xfer_count_t sum;
    int unsigned ready_bits;
    int unsigned want_bits;
    drain_pending(1'b0);
    offer_cycle('1, 0, 1'b1);
    sum = '0;
    for (int c = 0; c < 10; c++) begin
      draw_bits(num_flows, ready_bits);
      draw_bits(3, want_bits);
      offer_cycle(num_flows'(ready_bits), int'(want_bits % (num_symbols + 1)), 1'b0);
      check_stat("xfer_count", sum, xfer_count);
      sum = sum + mxd_stats_pkg::xfer_count_t'(exp_recv);
    end
    // Clear wins over symbols taken in the same cycle
    offer_cycle('1, num_symbols, 1'b1);
    check_stat("xfer_count", sum, xfer_count);
    offer_cycle('1, 0, 1'b0);
    check_stat("xfer_count", '0, xfer_count);
  endtask

  initial begin
    int total_errors;
    rst_n = 1'b0;
    push_sendable = '0;
    push_data = '0;
    pop_ready = '0;
    stat_clear = 1'b0;
    lfsr_state = lfsr_seed;
    model_ptr = 0;
    model_total = '0;
    held = 0;
    count_errors = 0;
    flag_errors = 0;
    symbol_errors = 0;
    stat_errors = 0;
    timeout_errors = 0;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_state_test();
    full_rotation_test();
    partial_ready_test();
    shortage_reoffer_test();
    statistics_test();
    total_errors = count_errors + flag_errors + symbol_errors + stat_errors + timeout_errors;
    $display("Errors: count %0d, flags %0d, symbol %0d, stat %0d, timeout %0d",
             count_errors, flag_errors, symbol_errors, stat_errors, timeout_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Whole-run limit in case a test never returns
  initial begin
    #200000;
    $display("Timeout: simulation ran past its time limit");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule : tb_mxd_distributor

`default_nettype wire
